//--- verilog.f
if_stats_pkg.sv
cpu_reg_port.sv
packet_counter.sv
status_capture.sv
ctrl_regs.sv
if_stats_top.sv
if_stats_sva.sv
if_stats_tb.sv

//--- Bender.yml
package:
  name: if_stats

sources:
  - if_stats_pkg.sv
  - cpu_reg_port.sv
  - packet_counter.sv
  - status_capture.sv
  - ctrl_regs.sv
  - if_stats_top.sv
  - target: simulation
    files:
      - if_stats_sva.sv
      - if_stats_tb.sv

//--- if_stats_tb.sv
// Interface statistics testbench
module if_stats_tb;

   localparam int max_rows = 64;
   localparam logic [7:0] port_number = 8'h07;
   localparam logic [1:0] mac_value = 2'b10;
   localparam logic [7:0] pcs_value = 8'hb5;

   logic                      core_clk;
   logic                      reset;
   logic                      cpu_req;
   logic                      cpu_write;
   if_stats_pkg::reg_addr_t   cpu_addr;
   if_stats_pkg::reg_word_t   cpu_wdata;
   logic                      cpu_ack;
   if_stats_pkg::reg_word_t   cpu_rdata;
   logic                      rx_tvalid;
   logic                      rx_tready;
   logic                      rx_tlast;
   logic                      tx_tvalid;
   logic                      tx_tready;
   logic                      tx_tlast;
   if_stats_pkg::mac_status_t mac_status;
   if_stats_pkg::pcs_status_t pcs_status;
   if_stats_pkg::pcs_vector_t pcs_vector;
   if_stats_pkg::port_num_t   interface_number;

   // Stimulus and expected values, one entry per CPU transaction
   string       row_name [max_rows];
   logic        row_write [max_rows];
   logic [7:0]  row_addr [max_rows];
   logic [31:0] row_wdata [max_rows];
   int          row_rx [max_rows];
   int          row_tx [max_rows];
   logic [31:0] row_expect [max_rows];
   int          num_rows;
   int          cycle_count;
   int          cycle_limit;

   if_stats_top #(.pkt_count_width(4)) i_if_stats_top (
      .core_clk, .reset, .cpu_req, .cpu_write, .cpu_addr, .cpu_wdata, .cpu_ack, .cpu_rdata,
      .rx_tvalid, .rx_tready, .rx_tlast, .tx_tvalid, .tx_tready, .tx_tlast,
      .mac_status, .pcs_status, .pcs_vector, .interface_number
   );

   initial core_clk = 1'b0;
   always #20 core_clk = ~core_clk;

   always @(posedge core_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("Timeout after %0d cycles, the test sequence did not complete", cycle_count);
         $display("Finished with errors");
         $fatal(1);
      end
   end

   // Content of status vector word k
   function automatic logic [31:0] vector_pattern(input int k);
      logic [7:0] idx;
      idx = 8'(k);
      return {8'hc0 + idx, 8'(idx * 8'd37), ~idx, 8'h5a ^ idx};
   endfunction

   task automatic add_row(input string name, input logic write, input logic [7:0] addr,
                          input logic [31:0] wdata, input int rx, input int tx,
                          input logic [31:0] expect_data);
      row_name[num_rows]   = name;
      row_write[num_rows]  = write;
      row_addr[num_rows]   = addr;
      row_wdata[num_rows]  = wdata;
      row_rx[num_rows]     = rx;
      row_tx[num_rows]     = tx;
      row_expect[num_rows] = expect_data;
      num_rows = num_rows + 1;
   endtask

   task automatic build_table();
      num_rows = 0;
      add_row("id_read", 1'b0, 8'h00, 0, 0, 0, {4'h1, 4'h0, port_number, 16'h2d10});
      add_row("version_read", 1'b0, 8'h04, 0, 0, 0, 32'h0000_0100);
      add_row("interface_id_read", 1'b0, 8'h14, 0, 0, 0, {24'h0, port_number});
      add_row("reset_read", 1'b0, 8'h08, 0, 0, 0, 32'h0);
      add_row("flip_write", 1'b1, 8'h0c, 32'h1234_5678, 0, 0, 32'h0);
      add_row("flip_read", 1'b0, 8'h0c, 0, 0, 0, 32'hedcb_a987);
      add_row("debug_write", 1'b1, 8'h10, 32'h0000_0a05, 0, 0, 32'h0);
      add_row("debug_read", 1'b0, 8'h10, 0, 0, 0, 32'h0000_0a15);
      // Counters clear when read
      add_row("pkt_in_read", 1'b0, 8'h18, 0, 3, 5, 32'd3);
      add_row("pkt_out_read", 1'b0, 8'h1c, 0, 0, 0, 32'd5);
      add_row("pkt_in_reread", 1'b0, 8'h18, 0, 0, 0, 32'd0);
      add_row("pkt_out_reread", 1'b0, 8'h1c, 0, 0, 0, 32'd0);
      // Sticky wrap bit plus 9 mod 8
      add_row("pkt_in_wrap", 1'b0, 8'h18, 0, 9, 0, 32'h9);
      add_row("clear_bit_write", 1'b1, 8'h08, 32'h1, 2, 3, 32'h0);
      add_row("pkt_in_after_clear", 1'b0, 8'h18, 0, 0, 0, 32'd0);
      add_row("pkt_out_after_clear", 1'b0, 8'h1c, 0, 0, 0, 32'd0);
      add_row("flip_after_clear", 1'b0, 8'h0c, 0, 0, 0, 32'hedcb_a987);
      add_row("debug_after_clear", 1'b0, 8'h10, 0, 0, 0, 32'h0000_0a15);
      add_row("regs_bit_write", 1'b1, 8'h08, 32'h10, 4, 1, 32'h0);
      add_row("pkt_in_after_regs", 1'b0, 8'h18, 0, 0, 0, 32'd0);
      add_row("pkt_out_after_regs", 1'b0, 8'h1c, 0, 0, 0, 32'd0);
      add_row("flip_after_regs", 1'b0, 8'h0c, 0, 0, 0, 32'hffff_ffff);
      add_row("debug_after_regs", 1'b0, 8'h10, 0, 0, 0, 32'h0000_0010);
      add_row("mac_status_read", 1'b0, 8'h20, 0, 0, 0, {30'h0, mac_value});
      add_row("pcs_status_read", 1'b0, 8'h24, 0, 0, 0, {24'h0, pcs_value});
      for (int k = 0; k < 14; k++) begin
         add_row($sformatf("vector_word_%0d", k), 1'b0, 8'(8'h28 + 4 * k), 0, 0, 0,
                 vector_pattern(k));
      end
      add_row("unmapped_after_vector", 1'b0, 8'h60, 0, 0, 0, 32'h0);
      add_row("unaligned_in_vector", 1'b0, 8'h2a, 0, 0, 0, 32'h0);
      add_row("unmapped_top", 1'b0, 8'hfc, 0, 0, 0, 32'h0);
   endtask

   // Inputs change shortly after the rising edge
   task automatic next_cycle();
      @(posedge core_clk);
      #2;
   endtask

   task automatic set_stream(input bit is_rx, input logic valid, input logic ready,
                             input logic last);
      if (is_rx) begin
         rx_tvalid = valid;
         rx_tready = ready;
         rx_tlast  = last;
      end else begin
         tx_tvalid = valid;
         tx_tready = ready;
         tx_tlast  = last;
      end
   endtask

   task automatic send_packets(input bit is_rx, input int count);
      int gap;
      for (int p = 0; p < count; p++) begin
         gap = $urandom_range(2, 0);
         // Idle cycles with last and ready up but no valid beat
         repeat (gap) begin
            set_stream(is_rx, 1'b0, 1'b1, 1'b1);
            next_cycle();
         end
         // Body beat, not the end of a packet
         if ($urandom_range(1, 0) == 1) begin
            set_stream(is_rx, 1'b1, 1'b1, 1'b0);
            next_cycle();
         end
         // Last beat stalled by the sink
         if ($urandom_range(1, 0) == 1) begin
            set_stream(is_rx, 1'b1, 1'b0, 1'b1);
            next_cycle();
         end
         set_stream(is_rx, 1'b1, 1'b1, 1'b1);
         next_cycle();
      end
      set_stream(is_rx, 1'b0, 1'b0, 1'b0);
   endtask

   task automatic cpu_transfer(input logic write, input logic [7:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
      cpu_req   = 1'b1;
      cpu_write = write;
      cpu_addr  = addr;
      cpu_wdata = wdata;
      do begin
         next_cycle();
      end while (!cpu_ack);
      rdata   = cpu_rdata;
      cpu_req = 1'b0;
      do begin
         next_cycle();
      end while (cpu_ack);
   endtask

   initial begin
      logic [31:0] got;
      void'($urandom(32'h32a0));
      cycle_count      = 0;
      reset            = 1'b1;
      cpu_req          = 1'b0;
      cpu_write        = 1'b0;
      cpu_addr         = '0;
      cpu_wdata        = '0;
      rx_tvalid        = 1'b0;
      rx_tready        = 1'b0;
      rx_tlast         = 1'b0;
      tx_tvalid        = 1'b0;
      tx_tready        = 1'b0;
      tx_tlast         = 1'b0;
      mac_status       = mac_value;
      pcs_status       = pcs_value;
      interface_number = port_number;
      for (int k = 0; k < 14; k++) begin
         pcs_vector[k * 32 +: 32] = vector_pattern(k);
      end
      build_table();
      cycle_limit = num_rows * 60 + 500;
      repeat (2) @(posedge core_clk);
      #2;
      reset = 1'b0;
      for (int i = 0; i < num_rows; i++) begin
         send_packets(1'b1, row_rx[i]);
         send_packets(1'b0, row_tx[i]);
         cpu_transfer(row_write[i], row_addr[i], row_wdata[i], got);
         if (!row_write[i]) begin
            assert (got === row_expect[i])
            else begin
               $display("mismatch in %s: expected %08h, actual %08h",
                        row_name[i], row_expect[i], got);
               $display("Finished with errors");
               $fatal(1);
            end
         end
      end
      $display("Finished with no errors");
      $finish;
   end

endmodule

//--- if_stats_sva.sv
// CPU port handshake checks
module if_stats_sva (
   input logic core_clk,
   input logic reset,
   input logic cpu_req,
   input logic cpu_ack,
   input logic acc_stb
);

   // Ack only rises in answer to a pending req
   ack_rise_needs_req: assert property (
      @(posedge core_clk) disable iff (reset) $rose(cpu_ack) |-> $past(cpu_req)
   ) else $error("cpu_ack rose without cpu_req");

   // Ack is released only once req has gone low
   ack_fall_after_req: assert property (
      @(posedge core_clk) disable iff (reset) $fell(cpu_ack) |-> $past(!cpu_req)
   ) else $error("cpu_ack fell while cpu_req was still high");

   // One strobe cycle, then ack
   stb_single_cycle: assert property (
      @(posedge core_clk) disable iff (reset) acc_stb |=> (cpu_ack && !acc_stb)
   ) else $error("acc_stb longer than one cycle or not followed by cpu_ack");

endmodule

bind cpu_reg_port if_stats_sva i_if_stats_sva (
   .core_clk, .reset, .cpu_req, .cpu_ack, .acc_stb
);

//--- if_stats_top.sv
// Interface statistics block
module if_stats_top #(
   parameter int pkt_count_width = if_stats_pkg::pkt_count_width_default
) (
   input  logic                      core_clk,
   input  logic                      reset,
   input  logic                      cpu_req,
   input  logic                      cpu_write,
   input  if_stats_pkg::reg_addr_t   cpu_addr,
   input  if_stats_pkg::reg_word_t   cpu_wdata,
   output logic                      cpu_ack,
   output if_stats_pkg::reg_word_t   cpu_rdata,
   input  logic                      rx_tvalid,
   input  logic                      rx_tready,
   input  logic                      rx_tlast,
   input  logic                      tx_tvalid,
   input  logic                      tx_tready,
   input  logic                      tx_tlast,
   input  if_stats_pkg::mac_status_t mac_status,
   input  if_stats_pkg::pcs_status_t pcs_status,
   input  if_stats_pkg::pcs_vector_t pcs_vector,
   input  if_stats_pkg::port_num_t   interface_number
);

   logic                      acc_stb;
   logic                      acc_write;
   if_stats_pkg::reg_addr_t   acc_addr;
   if_stats_pkg::reg_word_t   acc_wdata;
   if_stats_pkg::reg_word_t   acc_rdata;
   if_stats_pkg::reg_word_t   rx_count;
   if_stats_pkg::reg_word_t   tx_count;
   logic                      rx_clear;
   logic                      tx_clear;
   if_stats_pkg::mac_status_t mac_status_q;
   if_stats_pkg::pcs_status_t pcs_status_q;
   logic [3:0]                word_index;
   if_stats_pkg::reg_word_t   vector_word;

   cpu_reg_port i_cpu_reg_port (
      .core_clk, .reset, .cpu_req, .cpu_write, .cpu_addr, .cpu_wdata,
      .cpu_ack, .cpu_rdata, .acc_stb, .acc_write, .acc_addr, .acc_wdata, .acc_rdata
   );

   // Packets towards the DMA
   packet_counter #(.count_width(pkt_count_width)) rx_counter (
      .core_clk, .reset, .pkt_valid(rx_tvalid), .pkt_ready(rx_tready),
      .pkt_last(rx_tlast), .clear(rx_clear), .count(rx_count)
   );

   // Packets from the DMA
   packet_counter #(.count_width(pkt_count_width)) tx_counter (
      .core_clk, .reset, .pkt_valid(tx_tvalid), .pkt_ready(tx_tready),
      .pkt_last(tx_tlast), .clear(tx_clear), .count(tx_count)
   );

   status_capture i_status_capture (
      .core_clk, .reset, .mac_status, .pcs_status, .pcs_vector,
      .word_index, .mac_status_q, .pcs_status_q, .vector_word
   );

   ctrl_regs i_ctrl_regs (
      .core_clk, .reset, .acc_stb, .acc_write, .acc_addr, .acc_wdata, .acc_rdata,
      .interface_number, .rx_count, .tx_count, .rx_clear, .tx_clear,
      .mac_status_q, .pcs_status_q, .word_index, .vector_word
   );

endmodule

//--- ctrl_regs.sv
// Register file and read decode
module ctrl_regs (
   input  logic                      core_clk,
   input  logic                      reset,
   input  logic                      acc_stb,
   input  logic                      acc_write,
   input  if_stats_pkg::reg_addr_t   acc_addr,
   input  if_stats_pkg::reg_word_t   acc_wdata,
   output if_stats_pkg::reg_word_t   acc_rdata,
   input  if_stats_pkg::port_num_t   interface_number,
   input  if_stats_pkg::reg_word_t   rx_count,
   input  if_stats_pkg::reg_word_t   tx_count,
   output logic                      rx_clear,
   output logic                      tx_clear,
   input  if_stats_pkg::mac_status_t mac_status_q,
   input  if_stats_pkg::pcs_status_t pcs_status_q,
   output logic [3:0]                word_index,
   input  if_stats_pkg::reg_word_t   vector_word
);

   if_stats_pkg::reg_word_t flip_q;
   if_stats_pkg::reg_word_t debug_q;
   logic                    wr_stb;
   logic                    rd_stb;
   logic                    reset_wr;
   logic                    clear_all;
   logic                    regs_default;
   logic                    vector_hit;

   assign wr_stb = acc_stb & acc_write;
   assign rd_stb = acc_stb & ~acc_write;

   // Reset register actions, the register itself stores nothing
   assign reset_wr     = wr_stb && (acc_addr == if_stats_pkg::addr_reset);
   assign regs_default = reset_wr & acc_wdata[if_stats_pkg::reset_regs_bit];
   assign clear_all    = reset_wr & (acc_wdata[if_stats_pkg::reset_clear_bit] |
                                     acc_wdata[if_stats_pkg::reset_regs_bit]);

   // Counters clear on read of their own address
   assign rx_clear = clear_all | (rd_stb && (acc_addr == if_stats_pkg::addr_pkt_in));
   assign tx_clear = clear_all | (rd_stb && (acc_addr == if_stats_pkg::addr_pkt_out));

   always_ff @(posedge core_clk) begin
      if (reset || regs_default) begin
         flip_q  <= if_stats_pkg::flip_default;
         debug_q <= if_stats_pkg::debug_default;
      end else if (wr_stb) begin
         if (acc_addr == if_stats_pkg::addr_flip) begin
            flip_q <= acc_wdata;
         end
         if (acc_addr == if_stats_pkg::addr_debug) begin
            debug_q <= acc_wdata;
         end
      end
   end

   // Word aligned address inside the status vector window
   assign vector_hit = (acc_addr >= if_stats_pkg::addr_vector_first) &&
                       (acc_addr <= if_stats_pkg::addr_vector_last) &&
                       (acc_addr[1:0] == 2'b00);
   assign word_index = 4'((acc_addr - if_stats_pkg::addr_vector_first) >> 2);

   always_comb begin
      acc_rdata = '0;
      case (acc_addr)
         if_stats_pkg::addr_id: begin
            // Kind, spare nibble, port number, block code
            acc_rdata = {if_stats_pkg::id_kind, 4'h0, interface_number,
                         if_stats_pkg::block_code};
         end
         if_stats_pkg::addr_version:      acc_rdata = if_stats_pkg::version_default;
         if_stats_pkg::addr_reset:        acc_rdata = '0;
         if_stats_pkg::addr_flip:         acc_rdata = ~flip_q;
         if_stats_pkg::addr_debug:        acc_rdata = if_stats_pkg::debug_base + debug_q;
         if_stats_pkg::addr_interface_id: acc_rdata = 32'(interface_number);
         if_stats_pkg::addr_pkt_in:       acc_rdata = rx_count;
         if_stats_pkg::addr_pkt_out:      acc_rdata = tx_count;
         if_stats_pkg::addr_mac_status:   acc_rdata = 32'(mac_status_q);
         if_stats_pkg::addr_pcs_status:   acc_rdata = 32'(pcs_status_q);
         default: begin
            if (vector_hit) begin
               acc_rdata = vector_word;
            end
         end
      endcase
   end

endmodule

//--- status_capture.sv
// MAC and PCS/PMA status capture
module status_capture (
   input  logic                        core_clk,
   input  logic                        reset,
   input  if_stats_pkg::mac_status_t   mac_status,
   input  if_stats_pkg::pcs_status_t   pcs_status,
   input  if_stats_pkg::pcs_vector_t   pcs_vector,
   input  logic [3:0]                  word_index,
   output if_stats_pkg::mac_status_t   mac_status_q,
   output if_stats_pkg::pcs_status_t   pcs_status_q,
   output if_stats_pkg::reg_word_t     vector_word
);

   if_stats_pkg::pcs_vector_t pcs_vector_q;

   // Status flags sampled every cycle
   always_ff @(posedge core_clk) begin
      if (reset) begin
         mac_status_q <= '0;
         pcs_status_q <= '0;
      end else begin
         mac_status_q <= mac_status;
         pcs_status_q <= pcs_status;
      end
   end

   always_ff @(posedge core_clk) begin
      pcs_vector_q <= pcs_vector;
   end

   // Word 0 sits in the least significant bits
   always_comb begin
      if (word_index < 4'(if_stats_pkg::pcs_vector_words)) begin
         vector_word = pcs_vector_q[word_index * if_stats_pkg::reg_word_width +:
                                    if_stats_pkg::reg_word_width];
      end else begin
         vector_word = '0;
      end
   end

endmodule

//--- packet_counter.sv
// Packet counter with sticky wrap flag
module packet_counter #(
   parameter int count_width = if_stats_pkg::pkt_count_width_default
) (
   input  logic                    core_clk,
   input  logic                    reset,
   input  logic                    pkt_valid,
   input  logic                    pkt_ready,
   input  logic                    pkt_last,
   input  logic                    clear,
   output if_stats_pkg::reg_word_t count
);

   // Low bits count packets, the top bit remembers a wrap
   logic [count_width-2:0] low_q;
   logic                   wrap_q;
   logic                   pkt_done;

   // Last beat of a packet accepted by the sink
   assign pkt_done = pkt_valid & pkt_ready & pkt_last;

   always_ff @(posedge core_clk) begin
      if (reset || clear) begin
         // Clear wins over a packet ending on the same edge
         low_q  <= '0;
         wrap_q <= 1'b0;
      end else if (pkt_done) begin
         low_q <= low_q + 1'b1;
         if (&low_q) begin
            wrap_q <= 1'b1;
         end
      end
   end

   assign count = if_stats_pkg::reg_word_t'({wrap_q, low_q});

endmodule

//--- cpu_reg_port.sv
// CPU register port slave
module cpu_reg_port (
   input  logic                   core_clk,
   input  logic                   reset,
   input  logic                   cpu_req,
   input  logic                   cpu_write,
   input  if_stats_pkg::reg_addr_t cpu_addr,
   input  if_stats_pkg::reg_word_t cpu_wdata,
   output logic                   cpu_ack,
   output if_stats_pkg::reg_word_t cpu_rdata,
   output logic                   acc_stb,
   output logic                   acc_write,
   output if_stats_pkg::reg_addr_t acc_addr,
   output if_stats_pkg::reg_word_t acc_wdata,
   input  if_stats_pkg::reg_word_t acc_rdata
);

   if_stats_pkg::port_state_t state;

   always_ff @(posedge core_clk) begin
      if (reset) begin
         state     <= if_stats_pkg::idle;
         cpu_rdata <= '0;
      end else begin
         case (state)
            if_stats_pkg::idle: begin
               if (cpu_req) begin
                  state <= if_stats_pkg::acking;
               end
            end
            if_stats_pkg::acking: begin
               // Single access cycle, capture what the decode returns
               cpu_rdata <= acc_rdata;
               state     <= if_stats_pkg::wait_release;
            end
            if_stats_pkg::wait_release: begin
               // Hold ack until the master lets go of req
               if (!cpu_req) begin
                  state <= if_stats_pkg::idle;
               end
            end
            default: begin
               state <= if_stats_pkg::idle;
            end
         endcase
      end
   end

   // Ack is high from the access edge until req is seen low
   assign cpu_ack = (state == if_stats_pkg::wait_release);

   // Strobe for exactly one cycle per transaction
   assign acc_stb = (state == if_stats_pkg::acking);

   // Master holds these stable while req is high
   assign acc_write = cpu_write;
   assign acc_addr  = cpu_addr;
   assign acc_wdata = cpu_wdata;

endmodule

//--- if_stats_pkg.sv
// Interface statistics definitions
package if_stats_pkg;

   // Register port widths
   localparam int reg_word_width = 32;
   localparam int reg_addr_width = 8;

   // PCS/PMA status vector is read back in whole register words
   localparam int pcs_vector_words = 14;
   localparam int pcs_vector_width = pcs_vector_words * reg_word_width;

   typedef logic [reg_word_width-1:0]   reg_word_t;
   typedef logic [reg_addr_width-1:0]   reg_addr_t;
   typedef logic [7:0]                  port_num_t;
   typedef logic [1:0]                  mac_status_t;
   typedef logic [7:0]                  pcs_status_t;
   typedef logic [pcs_vector_width-1:0] pcs_vector_t;

   // CPU port handshake states
   typedef enum logic [1:0] {
      idle,
      acking,
      wait_release
   } port_state_t;

   // Identification fields
   localparam logic [15:0] block_code = 16'h2d10;
   // Shared-logic flavour of the interface
   localparam logic [3:0]  id_kind    = 4'h1;

   localparam reg_word_t version_default = 32'h0000_0100;
   localparam reg_word_t debug_base      = 32'h0000_0010;
   localparam reg_word_t flip_default    = 32'h0000_0000;
   localparam reg_word_t debug_default   = 32'h0000_0000;

   // Counter width incl. the sticky wrap bit
   localparam int pkt_count_width_default = 32;

   // Bits of the reset register
   localparam int reset_clear_bit = 0;
   localparam int reset_regs_bit  = 4;

   // Register map, byte offsets
   localparam reg_addr_t addr_id           = 8'h00;
   localparam reg_addr_t addr_version      = 8'h04;
   localparam reg_addr_t addr_reset        = 8'h08;
   localparam reg_addr_t addr_flip         = 8'h0c;
   localparam reg_addr_t addr_debug        = 8'h10;
   localparam reg_addr_t addr_interface_id = 8'h14;
   localparam reg_addr_t addr_pkt_in       = 8'h18;
   localparam reg_addr_t addr_pkt_out      = 8'h1c;
   localparam reg_addr_t addr_mac_status   = 8'h20;
   localparam reg_addr_t addr_pcs_status   = 8'h24;

   // Status vector window, one word every 4 bytes
   localparam reg_addr_t addr_vector_first = 8'h28;
   localparam reg_addr_t addr_vector_last  =
      reg_addr_t'(addr_vector_first + 4 * (pcs_vector_words - 1));

endpackage
